// ==== common/toy_fp_pkg.sv ====
`default_nettype none

package toy_fp_pkg;

    // ================================================
    // widths
    // ================================================
    localparam int REG_WIDTH        = 32;
    localparam int PHY_REG_ID_WIDTH = 6;
    localparam int INST_IDX_WIDTH   = 5;
    localparam int FFLAGS_WIDTH     = 5;
    localparam int CLASS_WIDTH      = 10;

    // single precision field positions
    localparam int SIGN_BIT  = 31;
    localparam int EXP_MSB   = 30;
    localparam int EXP_LSB   = 23;
    localparam int QUIET_BIT = 22;

    // exception flag positions, nv is the only one this unit raises
    localparam int FLAG_NV = 4;

    // ================================================
    // special encodings
    // ================================================
    localparam logic [REG_WIDTH-1:0] CANONICAL_NAN     = 32'h7fc0_0000;
    localparam logic [REG_WIDTH-1:0] ZERO_POSITIVE     = 32'h0000_0000;
    localparam logic [REG_WIDTH-1:0] ZERO_NEGATIVE     = 32'h8000_0000;
    localparam logic [REG_WIDTH-1:0] INFINITY_POSITIVE = 32'h7f80_0000;
    localparam logic [REG_WIDTH-1:0] INFINITY_NEGATIVE = 32'hff80_0000;

    // ================================================
    // operation codes
    // ================================================
    // riscv funct5, upper bits of funct7
    typedef enum logic [4:0] {
        FLOAT_SGNJ       = 5'b00100,
        FLOAT_MINMAX     = 5'b00101,
        FLOAT_CMP        = 5'b10100,
        FLOAT_MVXW_CLASS = 5'b11100,
        FLOAT_MVWX       = 5'b11110
    } fp_funct5_e;

    // funct3 codes repeat across groups, so the enum holds the raw codes
    // and each group gets its own names on top of them
    typedef enum logic [2:0] {
        F3_000 = 3'b000,
        F3_001 = 3'b001,
        F3_010 = 3'b010
    } fp_funct3_e;

    localparam fp_funct3_e FSGNJ_SGNJ   = F3_000;
    localparam fp_funct3_e FSGNJ_SGNJ_N = F3_001;
    localparam fp_funct3_e FSGNJ_SGNJ_X = F3_010;
    localparam fp_funct3_e FMINMAX_MIN  = F3_000;
    localparam fp_funct3_e FMINMAX_MAX  = F3_001;
    localparam fp_funct3_e FCMP_FLE     = F3_000;
    localparam fp_funct3_e FCMP_FLT     = F3_001;
    localparam fp_funct3_e FCMP_FEQ     = F3_010;
    localparam fp_funct3_e FMVCL_MV     = F3_000;
    localparam fp_funct3_e FMVCL_CLASS  = F3_001;

    // ================================================
    // payload structs
    // ================================================
    typedef struct packed {
        fp_funct5_e                  funct5;
        fp_funct3_e                  funct3;
        logic [PHY_REG_ID_WIDTH-1:0] inst_rd;
        logic                        inst_rd_en;
        logic                        inst_fp_rd_en;
        logic [INST_IDX_WIDTH-1:0]   inst_id;
        logic [REG_WIDTH-1:0]        reg_rs1_val;
        logic [REG_WIDTH-1:0]        reg_rs2_val;
    } fp_inst_t;

    typedef struct packed {
        logic sign;
        logic is_nan;
        logic is_snan;
        logic is_zero;
    } fp_class_t;

    typedef struct packed {
        logic                 eq;
        logic                 lt;
        logic [REG_WIDTH-1:0] min_val;
        logic [REG_WIDTH-1:0] max_val;
        logic                 nv;
    } fp_cmp_t;

    typedef struct packed {
        logic [REG_WIDTH-1:0]        reg_val;
        logic [PHY_REG_ID_WIDTH-1:0] reg_index;
        logic                        reg_wr_en;
        logic                        fp_reg_wr_en;
        logic [INST_IDX_WIDTH-1:0]   reg_inst_idx;
        logic [FFLAGS_WIDTH-1:0]     fflags;
        logic                        fflags_en;
        logic                        commit_en;
    } fp_wb_t;

endpackage

`default_nettype wire

// ==== source/fp_classify.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_classify (
    input  wire logic [toy_fp_pkg::REG_WIDTH-1:0]   rs1_i,
    input  wire logic [toy_fp_pkg::REG_WIDTH-1:0]   rs2_i,
    output toy_fp_pkg::fp_class_t                   rs1_class_o,
    output toy_fp_pkg::fp_class_t                   rs2_class_o,
    output logic [toy_fp_pkg::CLASS_WIDTH-1:0]      class_mask_o
);
    import toy_fp_pkg::*;

    logic rs1_exp_max;
    logic rs1_exp_zero;
    logic rs1_man_zero;

    // sign, nan, snan and zero of one operand
    function automatic fp_class_t classify(input logic [REG_WIDTH-1:0] val);
        fp_class_t cls;
        logic      exp_max;
        logic      exp_zero;
        logic      man_zero;
        exp_max     = &val[EXP_MSB:EXP_LSB];
        exp_zero    = ~|val[EXP_MSB:EXP_LSB];
        man_zero    = ~|val[EXP_LSB-1:0];
        cls.sign    = val[SIGN_BIT];
        cls.is_nan  = exp_max & ~man_zero;
        cls.is_snan = exp_max & ~man_zero & ~val[QUIET_BIT];
        cls.is_zero = exp_zero & man_zero;
        return cls;
    endfunction

    assign rs1_class_o = classify(rs1_i);
    assign rs2_class_o = classify(rs2_i);

    assign rs1_exp_max  = &rs1_i[EXP_MSB:EXP_LSB];
    assign rs1_exp_zero = ~|rs1_i[EXP_MSB:EXP_LSB];
    assign rs1_man_zero = ~|rs1_i[EXP_LSB-1:0];

    // ================================================
    // fclass mask, rs1 only
    // ================================================
    assign class_mask_o[0] = rs1_i == INFINITY_NEGATIVE;
    assign class_mask_o[1] = rs1_i[SIGN_BIT] & ~rs1_exp_max & ~rs1_exp_zero;
    assign class_mask_o[2] = rs1_i[SIGN_BIT] & rs1_exp_zero & ~rs1_man_zero;
    assign class_mask_o[3] = rs1_i == ZERO_NEGATIVE;
    assign class_mask_o[4] = rs1_i == ZERO_POSITIVE;
    assign class_mask_o[5] = ~rs1_i[SIGN_BIT] & rs1_exp_zero & ~rs1_man_zero;
    assign class_mask_o[6] = ~rs1_i[SIGN_BIT] & ~rs1_exp_max & ~rs1_exp_zero;
    assign class_mask_o[7] = rs1_i == INFINITY_POSITIVE;
    // quiet bit set already implies a nonzero mantissa
    assign class_mask_o[8] = rs1_exp_max & ~rs1_man_zero & ~rs1_i[QUIET_BIT];
    assign class_mask_o[9] = rs1_exp_max & rs1_i[QUIET_BIT];

    // every encoding lands in exactly one class
    always_comb begin
        if (!$isunknown(rs1_i)) begin
            assert ($onehot(class_mask_o))
                else $error("fclass mask not one-hot for %h", rs1_i);
        end
    end

endmodule

`default_nettype wire

// ==== compare/fp_compare.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_compare (
    input  wire logic [toy_fp_pkg::REG_WIDTH-1:0]   rs1_i,
    input  wire logic [toy_fp_pkg::REG_WIDTH-1:0]   rs2_i,
    input  toy_fp_pkg::fp_funct3_e                  funct3_i,
    input  toy_fp_pkg::fp_class_t                   rs1_class_i,
    input  toy_fp_pkg::fp_class_t                   rs2_class_i,
    output toy_fp_pkg::fp_cmp_t                     cmp_o
);
    import toy_fp_pkg::*;

    logic                 any_nan;
    logic                 any_snan;
    logic                 both_zero;
    logic [REG_WIDTH-2:0] rs1_mag;
    logic [REG_WIDTH-2:0] rs2_mag;
    logic                 eq_raw;
    logic                 lt_raw;

    assign any_nan   = rs1_class_i.is_nan | rs2_class_i.is_nan;
    assign any_snan  = rs1_class_i.is_snan | rs2_class_i.is_snan;
    assign both_zero = rs1_class_i.is_zero & rs2_class_i.is_zero;

    assign rs1_mag = rs1_i[REG_WIDTH-2:0];
    assign rs2_mag = rs2_i[REG_WIDTH-2:0];

    // ================================================
    // ordered compare on sign-magnitude
    // ================================================
    // +0 and -0 compare equal
    assign eq_raw = (rs1_i == rs2_i) | both_zero;

    always_comb begin
        if (rs1_class_i.sign != rs2_class_i.sign) begin
            // negative side is smaller unless both are zeros
            lt_raw = rs1_class_i.sign & ~both_zero;
        end else if (rs1_class_i.sign) begin
            // both negative, larger magnitude is smaller
            lt_raw = rs1_mag > rs2_mag;
        end else begin
            lt_raw = rs1_mag < rs2_mag;
        end
    end

    // ================================================
    // outputs
    // ================================================
    always_comb begin
        // unordered when any nan is present
        cmp_o.eq = eq_raw & ~any_nan;
        cmp_o.lt = lt_raw & ~any_nan;

        if (rs1_class_i.is_nan && rs2_class_i.is_nan) begin
            cmp_o.min_val = CANONICAL_NAN;
            cmp_o.max_val = CANONICAL_NAN;
        end else if (rs1_class_i.is_nan) begin
            cmp_o.min_val = rs2_i;
            cmp_o.max_val = rs2_i;
        end else if (rs2_class_i.is_nan) begin
            cmp_o.min_val = rs1_i;
            cmp_o.max_val = rs1_i;
        end else if (both_zero) begin
            // -0 orders below +0
            cmp_o.min_val = (rs1_class_i.sign | rs2_class_i.sign) ? ZERO_NEGATIVE
                                                                   : ZERO_POSITIVE;
            cmp_o.max_val = (rs1_class_i.sign & rs2_class_i.sign) ? ZERO_NEGATIVE
                                                                   : ZERO_POSITIVE;
        end else begin
            cmp_o.min_val = lt_raw ? rs1_i : rs2_i;
            cmp_o.max_val = lt_raw ? rs2_i : rs1_i;
        end

        // feq is quiet, flt and fle signal on any nan
        if (funct3_i == FCMP_FEQ) begin
            cmp_o.nv = any_snan;
        end else begin
            cmp_o.nv = any_nan;
        end
    end

endmodule

`default_nettype wire

// ==== source/fp_result_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_result_mux (
    input  toy_fp_pkg::fp_inst_t                    inst_i,
    input  wire logic                               instruction_vld_i,
    input  toy_fp_pkg::fp_class_t                   rs1_class_i,
    input  toy_fp_pkg::fp_class_t                   rs2_class_i,
    input  wire logic [toy_fp_pkg::CLASS_WIDTH-1:0] class_mask_i,
    input  toy_fp_pkg::fp_cmp_t                     cmp_i,
    output logic [toy_fp_pkg::REG_WIDTH-1:0]        result_o,
    output logic                                    reg_wr_en_o,
    output logic                                    fp_reg_wr_en_o,
    output logic [toy_fp_pkg::FFLAGS_WIDTH-1:0]     fflags_o
);
    import toy_fp_pkg::*;

    logic [REG_WIDTH-1:0] rs1_val;
    logic [REG_WIDTH-1:0] rs2_val;
    logic                 int_dst;
    logic                 fp_dst;
    logic                 nv_flag;

    assign rs1_val = inst_i.reg_rs1_val;
    assign rs2_val = inst_i.reg_rs2_val;

    // ================================================
    // result and destination select
    // ================================================
    always_comb begin
        result_o = '0;
        int_dst  = 1'b0;
        fp_dst   = 1'b0;
        nv_flag  = 1'b0;
        case (inst_i.funct5)
            FLOAT_SGNJ: begin
                fp_dst = 1'b1;
                case (inst_i.funct3)
                    FSGNJ_SGNJ:   result_o = {rs2_val[SIGN_BIT], rs1_val[SIGN_BIT-1:0]};
                    FSGNJ_SGNJ_N: result_o = {~rs2_val[SIGN_BIT], rs1_val[SIGN_BIT-1:0]};
                    FSGNJ_SGNJ_X: begin
                        result_o = {rs1_val[SIGN_BIT] ^ rs2_val[SIGN_BIT],
                                    rs1_val[SIGN_BIT-1:0]};
                    end
                    default:      fp_dst = 1'b0;
                endcase
            end
            FLOAT_MINMAX: begin
                fp_dst = 1'b1;
                // codes overlap fle/flt, so the snan rule is applied here
                nv_flag = rs1_class_i.is_snan | rs2_class_i.is_snan;
                case (inst_i.funct3)
                    FMINMAX_MIN: result_o = cmp_i.min_val;
                    FMINMAX_MAX: result_o = cmp_i.max_val;
                    default: begin
                        fp_dst  = 1'b0;
                        nv_flag = 1'b0;
                    end
                endcase
            end
            FLOAT_CMP: begin
                int_dst = 1'b1;
                nv_flag = cmp_i.nv;
                case (inst_i.funct3)
                    FCMP_FEQ: result_o = {{(REG_WIDTH-1){1'b0}}, cmp_i.eq};
                    FCMP_FLT: result_o = {{(REG_WIDTH-1){1'b0}}, cmp_i.lt};
                    FCMP_FLE: result_o = {{(REG_WIDTH-1){1'b0}}, cmp_i.eq | cmp_i.lt};
                    default: begin
                        int_dst = 1'b0;
                        nv_flag = 1'b0;
                    end
                endcase
            end
            FLOAT_MVXW_CLASS: begin
                int_dst = 1'b1;
                case (inst_i.funct3)
                    FMVCL_MV:    result_o = rs1_val;
                    FMVCL_CLASS: result_o = {{(REG_WIDTH-CLASS_WIDTH){1'b0}}, class_mask_i};
                    default:     int_dst  = 1'b0;
                endcase
            end
            FLOAT_MVWX: begin
                if (inst_i.funct3 == FMVCL_MV) begin
                    fp_dst   = 1'b1;
                    result_o = rs1_val;
                end
            end
            default: begin
                // unsupported group, nothing written
                fp_dst = 1'b0;
            end
        endcase
    end

    assign reg_wr_en_o    = instruction_vld_i & int_dst & inst_i.inst_rd_en;
    assign fp_reg_wr_en_o = instruction_vld_i & fp_dst & inst_i.inst_fp_rd_en;

    always_comb begin
        fflags_o          = '0;
        fflags_o[FLAG_NV] = nv_flag;
    end

endmodule

`default_nettype wire

// ==== source/fp_writeback.sv ====
`timescale 1ns/100ps
`default_nettype none

module fp_writeback (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               instruction_vld_i,
    input  toy_fp_pkg::fp_inst_t                    inst_i,
    input  wire logic [toy_fp_pkg::REG_WIDTH-1:0]   result_i,
    input  wire logic                               reg_wr_en_i,
    input  wire logic                               fp_reg_wr_en_i,
    input  wire logic [toy_fp_pkg::FFLAGS_WIDTH-1:0] fflags_i,
    output toy_fp_pkg::fp_wb_t                      wb_o
);
    import toy_fp_pkg::*;

    // ================================================
    // write-back register
    // ================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_o <= '0;
        end else begin
            wb_o.reg_wr_en    <= reg_wr_en_i;
            wb_o.fp_reg_wr_en <= fp_reg_wr_en_i;
            wb_o.fflags_en    <= instruction_vld_i;
            wb_o.commit_en    <= instruction_vld_i;
            // payload holds the last accepted instruction
            if (instruction_vld_i) begin
                wb_o.reg_val      <= result_i;
                wb_o.reg_index    <= inst_i.inst_rd;
                wb_o.reg_inst_idx <= inst_i.inst_id;
                wb_o.fflags       <= fflags_i;
            end
        end
    end

    // one register file per instruction
    assert property (@(posedge clk) disable iff (reset_i)
        !(wb_o.reg_wr_en && wb_o.fp_reg_wr_en))
        else $error("integer and float write enables both high");

    // writes only come with a commit
    assert property (@(posedge clk) disable iff (reset_i)
        (wb_o.reg_wr_en || wb_o.fp_reg_wr_en || wb_o.fflags_en) |-> wb_o.commit_en)
        else $error("write-back enable without commit");

endmodule

`default_nettype wire

// ==== source/toy_float.sv ====
`timescale 1ns/100ps
`default_nettype none

module toy_float (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               instruction_vld_i,
    input  toy_fp_pkg::fp_inst_t    instruction_pld_i,
    output toy_fp_pkg::fp_wb_t      wb_o
);
    import toy_fp_pkg::*;

    fp_class_t               rs1_class;
    fp_class_t               rs2_class;
    logic [CLASS_WIDTH-1:0]  class_mask;
    fp_cmp_t                 cmp;
    logic [REG_WIDTH-1:0]    result;
    logic                    reg_wr_en;
    logic                    fp_reg_wr_en;
    logic [FFLAGS_WIDTH-1:0] fflags;

    // ================================================
    // combinational datapath
    // ================================================
    fp_classify fp_classify_inst (
        .rs1_i        (instruction_pld_i.reg_rs1_val),
        .rs2_i        (instruction_pld_i.reg_rs2_val),
        .rs1_class_o  (rs1_class),
        .rs2_class_o  (rs2_class),
        .class_mask_o (class_mask)
    );

    fp_compare fp_compare_inst (
        .rs1_i       (instruction_pld_i.reg_rs1_val),
        .rs2_i       (instruction_pld_i.reg_rs2_val),
        .funct3_i    (instruction_pld_i.funct3),
        .rs1_class_i (rs1_class),
        .rs2_class_i (rs2_class),
        .cmp_o       (cmp)
    );

    fp_result_mux fp_result_mux_inst (
        .inst_i            (instruction_pld_i),
        .instruction_vld_i (instruction_vld_i),
        .rs1_class_i       (rs1_class),
        .rs2_class_i       (rs2_class),
        .class_mask_i      (class_mask),
        .cmp_i             (cmp),
        .result_o          (result),
        .reg_wr_en_o       (reg_wr_en),
        .fp_reg_wr_en_o    (fp_reg_wr_en),
        .fflags_o          (fflags)
    );

    // one cycle to the write-back port
    fp_writeback fp_writeback_inst (
        .clk               (clk),
        .reset_i           (reset_i),
        .instruction_vld_i (instruction_vld_i),
        .inst_i            (instruction_pld_i),
        .result_i          (result),
        .reg_wr_en_i       (reg_wr_en),
        .fp_reg_wr_en_i    (fp_reg_wr_en),
        .fflags_i          (fflags),
        .wb_o              (wb_o)
    );

endmodule

`default_nettype wire

// ==== dv/toy_float_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module toy_float_tb;
    import toy_fp_pkg::*;

    localparam int unsigned SEED          = 32'hb5098823;
    localparam int          RESET_TIMEOUT = 20;
    localparam int          RANDOM_OPS    = 400;
    localparam int          NUM_CORNERS   = 13;

    logic     clk;
    logic     reset_i;
    logic     instruction_vld_i;
    fp_inst_t instruction_pld_i;
    fp_wb_t   wb_o;

    fp_wb_t exp_next;
    fp_wb_t exp_cur;
    logic   check_cur;
    int     value_errors;
    int     ctrl_errors;
    int     flag_errors;
    int     other_errors;
    int     commits_seen;
    int     valids_sent;

    toy_float toy_float_inst (
        .clk               (clk),
        .reset_i           (reset_i),
        .instruction_vld_i (instruction_vld_i),
        .instruction_pld_i (instruction_pld_i),
        .wb_o              (wb_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // reset released 1 ns after the second edge
    initial begin
        reset_i = 1'b1;
        repeat (2) @(posedge clk);
        #1 reset_i = 1'b0;
    end

    // ================================================
    // reference model
    // ================================================
    function automatic logic nan_bits(input logic [31:0] v);
        return (&v[30:23]) && (|v[22:0]);
    endfunction

    function automatic logic snan_bits(input logic [31:0] v);
        return nan_bits(v) && !v[22];
    endfunction

    // total order key where -0 sorts just below +0
    function automatic logic [31:0] order_key(input logic [31:0] v);
        return v[31] ? ~v : (v | 32'h8000_0000);
    endfunction

    function automatic logic [31:0] fclass_bits(input logic [31:0] v);
        logic [31:0] mask;
        int          pos;
        if (&v[30:23]) begin
            if (~|v[22:0]) pos = v[31] ? 0 : 7;
            else           pos = v[22] ? 9 : 8;
        end else if (~|v[30:23]) begin
            if (~|v[22:0]) pos = v[31] ? 3 : 4;
            else           pos = v[31] ? 2 : 5;
        end else begin
            pos = v[31] ? 1 : 6;
        end
        mask      = 32'h0;
        mask[pos] = 1'b1;
        return mask;
    endfunction

    function automatic fp_wb_t expected_wb(input logic vld, input fp_inst_t inst);
        fp_wb_t      exp;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] lo;
        logic [31:0] hi;
        logic [4:0]  f5;
        logic [2:0]  f3;
        logic        unordered;
        logic        both_zero;
        logic        eq;
        logic        lt;
        logic        int_dst;
        logic        fp_dst;
        logic        nv;
        a         = inst.reg_rs1_val;
        b         = inst.reg_rs2_val;
        f5        = inst.funct5;
        f3        = inst.funct3;
        unordered = nan_bits(a) || nan_bits(b);
        both_zero = (~|a[30:0]) && (~|b[30:0]);
        eq        = !unordered && ((a == b) || both_zero);
        lt        = !unordered && !both_zero && (order_key(a) < order_key(b));
        if (nan_bits(a) && nan_bits(b)) begin
            lo = 32'h7fc0_0000;
            hi = 32'h7fc0_0000;
        end else if (nan_bits(a) || nan_bits(b)) begin
            lo = nan_bits(a) ? b : a;
            hi = lo;
        end else if (both_zero) begin
            lo = {a[31] | b[31], 31'h0};
            hi = {a[31] & b[31], 31'h0};
        end else begin
            lo = lt ? a : b;
            hi = lt ? b : a;
        end
        res     = 32'h0;
        int_dst = 1'b0;
        fp_dst  = 1'b0;
        nv      = 1'b0;
        case (f5)
            5'b00100: begin
                fp_dst = (f3 <= 3'd2);
                if (f3 == 3'd0)      res = {b[31], a[30:0]};
                else if (f3 == 3'd1) res = {~b[31], a[30:0]};
                else if (f3 == 3'd2) res = {a[31] ^ b[31], a[30:0]};
            end
            5'b00101: begin
                fp_dst = (f3 <= 3'd1);
                nv     = fp_dst && (snan_bits(a) || snan_bits(b));
                if (f3 == 3'd0)      res = lo;
                else if (f3 == 3'd1) res = hi;
            end
            5'b10100: begin
                int_dst = (f3 <= 3'd2);
                // feq is the quiet compare
                if (f3 == 3'd2) begin
                    res = {31'h0, eq};
                    nv  = snan_bits(a) || snan_bits(b);
                end else if (f3 <= 3'd1) begin
                    res = {31'h0, (f3 == 3'd1) ? lt : (lt || eq)};
                    nv  = unordered;
                end
            end
            5'b11100: begin
                int_dst = (f3 <= 3'd1);
                if (f3 == 3'd0)      res = a;
                else if (f3 == 3'd1) res = fclass_bits(a);
            end
            5'b11110: begin
                fp_dst = (f3 == 3'd0);
                if (fp_dst) res = a;
            end
            default: res = 32'h0;
        endcase
        exp              = '0;
        exp.reg_val      = res;
        exp.reg_index    = inst.inst_rd;
        exp.reg_inst_idx = inst.inst_id;
        exp.fflags[FLAG_NV] = nv;
        exp.reg_wr_en    = vld && int_dst && inst.inst_rd_en;
        exp.fp_reg_wr_en = vld && fp_dst && inst.inst_fp_rd_en;
        exp.fflags_en    = vld;
        exp.commit_en    = vld;
        return exp;
    endfunction

    // ================================================
    // compare tasks
    // ================================================
    task automatic check_wb_value(input fp_wb_t got, input fp_wb_t exp);
        if (got.reg_val !== exp.reg_val || got.reg_index !== exp.reg_index ||
            got.reg_inst_idx !== exp.reg_inst_idx) begin
            $display("[FAIL] wb_o.reg_val/reg_index/reg_inst_idx got %h/%h/%h expected %h/%h/%h",
                     got.reg_val, got.reg_index, got.reg_inst_idx,
                     exp.reg_val, exp.reg_index, exp.reg_inst_idx);
            value_errors++;
        end
    endtask

    task automatic check_wb_ctrl(input fp_wb_t got, input fp_wb_t exp);
        logic [3:0] got_en;
        logic [3:0] exp_en;
        got_en = {got.reg_wr_en, got.fp_reg_wr_en, got.fflags_en, got.commit_en};
        exp_en = {exp.reg_wr_en, exp.fp_reg_wr_en, exp.fflags_en, exp.commit_en};
        if (got_en !== exp_en) begin
            $display("[FAIL] wb_o enables {reg,fp,fflags,commit} got %h expected %h at %0t",
                     got_en, exp_en, $time);
            ctrl_errors++;
        end
    endtask

    task automatic check_wb_flags(input fp_wb_t got, input fp_wb_t exp);
        if (got.fflags !== exp.fflags) begin
            $display("[FAIL] wb_o.fflags got %h expected %h at %0t",
                     got.fflags, exp.fflags, $time);
            flag_errors++;
        end
    endtask

    // one-entry delay compared at the falling edge
    always @(posedge clk) begin
        exp_cur   <= exp_next;
        check_cur <= !reset_i;
    end

    always @(negedge clk) begin
        if (check_cur) begin
            check_wb_ctrl(wb_o, exp_cur);
            if (exp_cur.commit_en) begin
                check_wb_value(wb_o, exp_cur);
                check_wb_flags(wb_o, exp_cur);
            end
            if (wb_o.commit_en) commits_seen++;
        end
    end

    // ================================================
    // stimulus
    // ================================================
    function automatic logic [31:0] corner_value(input int idx);
        case (idx)
            0:       return 32'h0000_0000;
            1:       return 32'h8000_0000;
            2:       return 32'h7f80_0000;
            3:       return 32'hff80_0000;
            4:       return 32'h7fc0_0000;
            5:       return 32'hffc0_0123;
            6:       return 32'h7f80_0001;
            7:       return 32'hffa0_0000;
            8:       return 32'h0000_0001;
            9:       return 32'h807f_ffff;
            10:      return 32'h3f80_0000;
            11:      return 32'hbf80_0000;
            default: return 32'h7f7f_ffff;
        endcase
    endfunction

    function automatic logic [31:0] pick_operand();
        int unsigned r;
        r = $urandom;
        if (r[0]) return corner_value(int'((r >> 1) % NUM_CORNERS));
        return $urandom;
    endfunction

    function automatic fp_inst_t make_inst(input logic [4:0] f5, input logic [2:0] f3,
                                           input logic [31:0] a, input logic [31:0] b);
        fp_inst_t    inst;
        int unsigned r;
        r                  = $urandom;
        inst.funct5        = fp_funct5_e'(f5);
        inst.funct3        = fp_funct3_e'(f3);
        inst.inst_rd       = r[5:0];
        inst.inst_id       = r[12:8];
        inst.inst_rd_en    = 1'b1;
        inst.inst_fp_rd_en = 1'b1;
        inst.reg_rs1_val   = a;
        inst.reg_rs2_val   = b;
        return inst;
    endfunction

    task automatic drive_cycle(input logic vld, input fp_inst_t inst);
        @(posedge clk);
        #1;
        instruction_vld_i = vld;
        instruction_pld_i = inst;
        exp_next          = expected_wb(vld, inst);
        if (vld) valids_sent++;
    endtask

    task automatic wait_reset_release(output logic released);
        int cycles;
        cycles = 0;
        while (reset_i !== 1'b0 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        released = (reset_i === 1'b0);
        if (!released) begin
            $display("timeout: reset was never released");
            other_errors++;
        end
    endtask

    task automatic directed_sweep();
        logic [2:0] f3;
        repeat (3) drive_cycle(1'b0, '0);
        for (int i = 0; i < NUM_CORNERS; i++) begin
            for (int k = 0; k < 3; k++) begin
                f3 = 3'(k);
                drive_cycle(1'b1, make_inst(5'b00100, f3, corner_value(i),
                                            corner_value((i + 5) % NUM_CORNERS)));
            end
            drive_cycle(1'b1, make_inst(5'b11100, 3'd0, corner_value(i), 32'h0));
            drive_cycle(1'b1, make_inst(5'b11110, 3'd0, corner_value(i), 32'h0));
            drive_cycle(1'b1, make_inst(5'b11100, 3'd1, corner_value(i), 32'h0));
            for (int j = 0; j < NUM_CORNERS; j++) begin
                for (int k = 0; k < 3; k++) begin
                    f3 = 3'(k);
                    drive_cycle(1'b1, make_inst(5'b10100, f3, corner_value(i), corner_value(j)));
                end
                drive_cycle(1'b1, make_inst(5'b00101, 3'd0, corner_value(i), corner_value(j)));
                drive_cycle(1'b1, make_inst(5'b00101, 3'd1, corner_value(i), corner_value(j)));
            end
        end
        // unsupported codes
        drive_cycle(1'b1, make_inst(5'b00101, 3'd2, 32'h3f80_0000, 32'hbf80_0000));
        drive_cycle(1'b1, make_inst(5'b11100, 3'd2, 32'h3f80_0000, 32'h0));
        drive_cycle(1'b1, make_inst(5'b11110, 3'd1, 32'h3f80_0000, 32'h0));
        drive_cycle(1'b1, make_inst(5'b00000, 3'd0, 32'h3f80_0000, 32'h0));
        drive_cycle(1'b1, make_inst(5'b11111, 3'd0, 32'h3f80_0000, 32'h0));
    endtask

    task automatic random_mix();
        fp_inst_t    inst;
        logic [4:0]  f5;
        int unsigned r;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = $urandom;
            case (r % 7)
                0:       f5 = 5'b00100;
                1:       f5 = 5'b00101;
                2:       f5 = 5'b10100;
                3:       f5 = 5'b11100;
                4:       f5 = 5'b11110;
                5:       f5 = 5'b00000;
                default: f5 = 5'b01011;
            endcase
            inst = make_inst(f5, 3'((r >> 4) % 3), pick_operand(), pick_operand());
            inst.inst_rd_en    = r[8];
            inst.inst_fp_rd_en = r[9];
            drive_cycle(r[11:10] != 2'b00, inst);
        end
    endtask

    initial begin
        int unsigned seed_dummy;
        logic        released;
        seed_dummy        = $urandom(SEED);
        instruction_vld_i = 1'b0;
        instruction_pld_i = '0;
        exp_next          = '0;
        check_cur         = 1'b0;
        value_errors      = 0;
        ctrl_errors       = 0;
        flag_errors       = 0;
        other_errors      = 0;
        commits_seen      = 0;
        valids_sent       = 0;
        wait_reset_release(released);
        if (released) begin
            directed_sweep();
            random_mix();
            repeat (2) drive_cycle(1'b0, '0);
            @(posedge clk);
            #6;
            if (commits_seen != valids_sent) begin
                $display("commit count %0d does not match %0d valid inputs",
                         commits_seen, valids_sent);
                other_errors++;
            end
        end
        $display("errors: value %0d, ctrl %0d, flags %0d, other %0d",
                 value_errors, ctrl_errors, flag_errors, other_errors);
        if (value_errors + ctrl_errors + flag_errors + other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
common/toy_fp_pkg.sv
source/fp_classify.sv
compare/fp_compare.sv
source/fp_result_mux.sv
source/fp_writeback.sv
source/toy_float.sv
dv/toy_float_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the toy_float testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=toy_float_sim

verilator --binary --timing --assert -f src.f --top-module toy_float_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^All checks passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
